//--- src.f
+incdir+verif
logic/rv_dec_pkg.sv
logic/rv_instr_if.sv
logic/rv_dec_stage_reg.sv
logic/rv_dec_ctrl.sv
logic/rv_dec_imm.sv
logic/rv_decode.sv
verif/tb_rv_decode.sv

//--- verif/rv_dec_model.svh
`ifndef RV_DEC_MODEL_SVH
`define RV_DEC_MODEL_SVH

// expected value of every decode output
typedef struct packed {
    logic [31:0]          pc;
    logic [31:0]          pc_next;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic [31:0]          imm;
    logic [31:0]          imm_jb;
    rv_dec_pkg::alu_op_t  alu_op;
    logic                 cmp_inv;
    logic [2:0]           funct3;
    logic                 op1_pc;
    rv_dec_pkg::op2_src_t op2_src;
    rv_dec_pkg::res_src_t res_src;
    logic                 reg_write;
    logic                 jal;
    logic                 jalr;
    logic                 branch;
    logic                 store;
    logic                 supported;
} dec_expect_t;

// class from opcode plus funct3/funct7/funct12 legality
function automatic rv_dec_pkg::instr_class_t classify_word(input logic [31:0] w);
    logic [2:0]               f3;
    logic [6:0]               f7;
    logic                     ok;
    rv_dec_pkg::instr_class_t cls;
    f3 = w[14:12];
    f7 = w[31:25];
    cls = rv_dec_pkg::CLS_UNSUPPORTED;
    case (w[6:2])
        rv_dec_pkg::OPC_LOAD:   cls = rv_dec_pkg::CLS_LOAD;
        rv_dec_pkg::OPC_STORE:  cls = rv_dec_pkg::CLS_STORE;
        rv_dec_pkg::OPC_OP_IMM: cls = rv_dec_pkg::CLS_OP_IMM;
        rv_dec_pkg::OPC_OP_REG: cls = rv_dec_pkg::CLS_OP_REG;
        rv_dec_pkg::OPC_LUI:    cls = rv_dec_pkg::CLS_LUI;
        rv_dec_pkg::OPC_AUIPC:  cls = rv_dec_pkg::CLS_AUIPC;
        rv_dec_pkg::OPC_BRANCH: cls = rv_dec_pkg::CLS_BRANCH;
        rv_dec_pkg::OPC_JAL:    cls = rv_dec_pkg::CLS_JAL;
        rv_dec_pkg::OPC_JALR:   cls = rv_dec_pkg::CLS_JALR;
        rv_dec_pkg::OPC_SYSTEM: cls = rv_dec_pkg::CLS_SYSTEM;
        default:                cls = rv_dec_pkg::CLS_UNSUPPORTED;
    endcase
    case (cls)
        rv_dec_pkg::CLS_LOAD:   ok = (f3 != 3'd3) && (f3 <= 3'd5);
        rv_dec_pkg::CLS_STORE:  ok = (f3 <= 3'd2);
        rv_dec_pkg::CLS_OP_IMM: ok = (f3 == 3'd1) ? (f7 == 7'd0) :
                                     (f3 == 3'd5) ? (f7 == 7'd0 || f7 == 7'd32) : 1'b1;
        rv_dec_pkg::CLS_OP_REG: ok = (f7 == 7'd0) || (f7 == 7'd32 && (f3 == 3'd0 || f3 == 3'd5));
        rv_dec_pkg::CLS_BRANCH: ok = (f3 != 3'd2) && (f3 != 3'd3);
        rv_dec_pkg::CLS_JALR:   ok = (f3 == 3'd0);
        // ecall and ebreak
        rv_dec_pkg::CLS_SYSTEM: ok = (f3 == 3'd0) && (w[31:21] == 11'd0);
        rv_dec_pkg::CLS_UNSUPPORTED: ok = 1'b0;
        default:                ok = 1'b1;
    endcase
    if (w == 32'h0)
        return rv_dec_pkg::CLS_NONE;
    if (w[1:0] != 2'b11 || !ok)
        return rv_dec_pkg::CLS_UNSUPPORTED;
    return cls;
endfunction

function automatic dec_expect_t expected_decode(input logic [31:0] w, input logic [31:0] pc);
    dec_expect_t              e;
    rv_dec_pkg::instr_class_t c;
    logic [2:0]               f3;
    logic                     alt;
    c = classify_word(w);
    f3 = w[14:12];
    alt = (w[31:25] == 7'd32);
    e.pc = pc;
    e.pc_next = pc + 32'd4;
    e.rs1 = (c == rv_dec_pkg::CLS_LUI) ? 5'd0 : w[19:15];
    e.rs2 = w[24:20];
    e.rd = w[11:7];
    e.funct3 = (w[1:0] == 2'b11) ? f3 : 3'd2;
    e.jal = (c == rv_dec_pkg::CLS_JAL);
    e.jalr = (c == rv_dec_pkg::CLS_JALR);
    e.branch = (c == rv_dec_pkg::CLS_BRANCH);
    e.store = (c == rv_dec_pkg::CLS_STORE);
    e.supported = (c != rv_dec_pkg::CLS_UNSUPPORTED);
    e.cmp_inv = e.branch && f3[0];
    e.op1_pc = (c == rv_dec_pkg::CLS_AUIPC) || e.jal;
    e.reg_write = c inside {rv_dec_pkg::CLS_LOAD, rv_dec_pkg::CLS_OP_IMM, rv_dec_pkg::CLS_OP_REG,
                            rv_dec_pkg::CLS_LUI, rv_dec_pkg::CLS_AUIPC, rv_dec_pkg::CLS_JAL,
                            rv_dec_pkg::CLS_JALR, rv_dec_pkg::CLS_SYSTEM};
    if (e.jal)
        e.op2_src = rv_dec_pkg::OP2_JUMP;
    else if (c inside {rv_dec_pkg::CLS_JALR, rv_dec_pkg::CLS_LOAD, rv_dec_pkg::CLS_OP_IMM,
                       rv_dec_pkg::CLS_LUI, rv_dec_pkg::CLS_AUIPC, rv_dec_pkg::CLS_STORE})
        e.op2_src = rv_dec_pkg::OP2_IMM;
    else
        e.op2_src = rv_dec_pkg::OP2_REG;
    if (c == rv_dec_pkg::CLS_LOAD)
        e.res_src = rv_dec_pkg::RES_MEMORY;
    else if (e.jal || e.jalr)
        e.res_src = rv_dec_pkg::RES_PC_NEXT;
    else
        e.res_src = rv_dec_pkg::RES_ALU;
    // immediates, sign always from bit 31
    if (c == rv_dec_pkg::CLS_LUI || c == rv_dec_pkg::CLS_AUIPC)
        e.imm = {w[31:12], 12'h000};
    else if (e.store)
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
    else
        e.imm = {{20{w[31]}}, w[31:20]};
    if (e.jal)
        e.imm_jb = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    else
        e.imm_jb = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    e.alu_op = rv_dec_pkg::ALU_ADD;
    if (c == rv_dec_pkg::CLS_OP_IMM || c == rv_dec_pkg::CLS_OP_REG)
    begin
        case (f3)
            3'd0: e.alu_op = (c == rv_dec_pkg::CLS_OP_REG && alt) ? rv_dec_pkg::ALU_SUB
                                                                   : rv_dec_pkg::ALU_ADD;
            3'd1: e.alu_op = rv_dec_pkg::ALU_SLL;
            3'd2: e.alu_op = rv_dec_pkg::ALU_CMP_LTS;
            3'd3: e.alu_op = rv_dec_pkg::ALU_CMP_LTU;
            3'd4: e.alu_op = rv_dec_pkg::ALU_XOR;
            3'd5: e.alu_op = alt ? rv_dec_pkg::ALU_SRA : rv_dec_pkg::ALU_SRL;
            3'd6: e.alu_op = rv_dec_pkg::ALU_OR;
            default: e.alu_op = rv_dec_pkg::ALU_AND;
        endcase
    end
    else if (e.branch)
    begin
        if (f3 <= 3'd1)
            e.alu_op = rv_dec_pkg::ALU_CMP_EQ;
        else if (f3 <= 3'd5)
            e.alu_op = rv_dec_pkg::ALU_CMP_LTS;
        else
            e.alu_op = rv_dec_pkg::ALU_CMP_LTU;
    end
    return e;
endfunction

`endif

//--- verif/tb_rv_decode.sv
`timescale 1ns/10ps

module tb_rv_decode;

`include "rv_dec_model.svh"

    localparam int MAX_CYCLES   = 400;
    localparam int RANDOM_WORDS = 200;

    logic                 i_clk;
    logic                 i_arst_n;
    logic                 i_stall;
    logic                 i_flush;
    logic [31:0]          i_instruction;
    logic [31:0]          i_pc;
    logic [31:0]          o_pc;
    logic [31:0]          o_pc_next;
    logic [4:0]           o_rs1;
    logic [4:0]           o_rs2;
    logic [4:0]           o_rd;
    logic [31:0]          o_imm;
    logic [31:0]          o_imm_jb;
    rv_dec_pkg::alu_op_t  o_alu_op;
    logic                 o_cmp_inv;
    logic [2:0]           o_funct3;
    logic                 o_op1_pc;
    rv_dec_pkg::op2_src_t o_op2_src;
    rv_dec_pkg::res_src_t o_res_src;
    logic                 o_reg_write;
    logic                 o_inst_jal;
    logic                 o_inst_jalr;
    logic                 o_inst_branch;
    logic                 o_inst_store;
    logic                 o_inst_supported;

    integer      seed;
    int          err_count;
    int          tests_ok;
    int          tests_bad;
    int          cycles;
    int          errs;
    logic [31:0] word;
    logic [31:0] cap_instr;
    logic [31:0] cap_pc;
    dec_expect_t expected;

    // one of each kind, then unsupported, compressed, csr, mret, fence
    logic [31:0] directed_words [0:41] = '{
        32'h00500093, 32'hfff0a113, 32'h0010b193, 32'h07f0c213, 32'h0ff0e293, 32'h00f0f313,
        32'h00309393, 32'h0040d413, 32'h4040d493, 32'h00208533, 32'h402085b3, 32'h00209633,
        32'h0020a6b3, 32'h0020b733, 32'h0020c7b3, 32'h0020d833, 32'h4020d8b3, 32'h0020e933,
        32'h0020f9b3, 32'h0080aa03, 32'hffc14a83, 32'h0020a623, 32'hfe310fa3, 32'h00208863,
        32'hfe209ce3, 32'h0020c863, 32'h0020d863, 32'h0020e863, 32'h0020f863, 32'h123452b7,
        32'hfffff317, 32'h001000ef, 32'hffdff06f, 32'h004280e7, 32'h00000073, 32'h00100073,
        32'h00000000, 32'h023100b3, 32'h00004501, 32'h30029073, 32'h30200073, 32'h0000000f
    };

    rv_dec_pkg::opcode_t valid_ops [0:9] = '{
        rv_dec_pkg::OPC_LOAD, rv_dec_pkg::OPC_OP_IMM, rv_dec_pkg::OPC_AUIPC,
        rv_dec_pkg::OPC_STORE, rv_dec_pkg::OPC_OP_REG, rv_dec_pkg::OPC_LUI,
        rv_dec_pkg::OPC_BRANCH, rv_dec_pkg::OPC_JALR, rv_dec_pkg::OPC_JAL,
        rv_dec_pkg::OPC_SYSTEM
    };

    rv_decode UUT
    (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_stall          (i_stall),
        .i_flush          (i_flush),
        .i_instruction    (i_instruction),
        .i_pc             (i_pc),
        .o_pc             (o_pc),
        .o_pc_next        (o_pc_next),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_imm            (o_imm),
        .o_imm_jb         (o_imm_jb),
        .o_alu_op         (o_alu_op),
        .o_cmp_inv        (o_cmp_inv),
        .o_funct3         (o_funct3),
        .o_op1_pc         (o_op1_pc),
        .o_op2_src        (o_op2_src),
        .o_res_src        (o_res_src),
        .o_reg_write      (o_reg_write),
        .o_inst_jal       (o_inst_jal),
        .o_inst_jalr      (o_inst_jalr),
        .o_inst_branch    (o_inst_branch),
        .o_inst_store     (o_inst_store),
        .o_inst_supported (o_inst_supported)
    );

    always #2 i_clk = ~i_clk;

    task automatic compare_value(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("ERR at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
            err_count++;
        end
    endtask

    task automatic drive_word(input logic [31:0] w, input logic [31:0] pc,
                              input logic stall, input logic flush);
        @(posedge i_clk);
        i_instruction <= w;
        i_pc          <= pc;
        i_stall       <= stall;
        i_flush       <= flush;
    endtask

    // decode of an empty slot at a given pc
    task automatic check_bubble(input logic [31:0] pc);
        compare_value("o_reg_write", 32'd0, o_reg_write);
        compare_value("o_inst_store", 32'd0, o_inst_store);
        compare_value("o_inst_branch", 32'd0, o_inst_branch);
        compare_value("o_inst_jal", 32'd0, o_inst_jal);
        compare_value("o_inst_jalr", 32'd0, o_inst_jalr);
        compare_value("o_inst_supported", 32'd1, o_inst_supported);
        compare_value("o_pc", pc, o_pc);
        compare_value("o_pc_next", pc + 32'd4, o_pc_next);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("%s: ok", name);
            tests_ok++;
        end
        else
        begin
            $display("%s: FAILED with %0d mismatches", name, err_count - errs_before);
            tests_bad++;
        end
    endtask

    // what the stage should hold, tracked from the inputs
    always @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            cap_instr <= 32'h0;
            cap_pc    <= 32'h0;
        end
        else if (i_flush)
        begin
            cap_instr <= 32'h0;
        end
        else if (!i_stall)
        begin
            cap_instr <= i_instruction;
            cap_pc    <= i_pc;
        end
    end

    // outputs are settled mid-cycle
    always @(negedge i_clk)
    begin
        expected = expected_decode(cap_instr, cap_pc);
        compare_value("o_pc", expected.pc, o_pc);
        compare_value("o_pc_next", expected.pc_next, o_pc_next);
        compare_value("o_rs1", expected.rs1, o_rs1);
        compare_value("o_rs2", expected.rs2, o_rs2);
        compare_value("o_rd", expected.rd, o_rd);
        compare_value("o_imm", expected.imm, o_imm);
        compare_value("o_imm_jb", expected.imm_jb, o_imm_jb);
        compare_value("o_alu_op", expected.alu_op, o_alu_op);
        compare_value("o_cmp_inv", expected.cmp_inv, o_cmp_inv);
        compare_value("o_funct3", expected.funct3, o_funct3);
        compare_value("o_op1_pc", expected.op1_pc, o_op1_pc);
        compare_value("o_op2_src", expected.op2_src, o_op2_src);
        compare_value("o_res_src", expected.res_src, o_res_src);
        compare_value("o_reg_write", expected.reg_write, o_reg_write);
        compare_value("o_inst_jal", expected.jal, o_inst_jal);
        compare_value("o_inst_jalr", expected.jalr, o_inst_jalr);
        compare_value("o_inst_branch", expected.branch, o_inst_branch);
        compare_value("o_inst_store", expected.store, o_inst_store);
        compare_value("o_inst_supported", expected.supported, o_inst_supported);
    end

    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        seed          = 32'h343a;
        i_clk         = 1'b0;
        i_arst_n      = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_instruction = 32'h0;
        i_pc          = 32'h0;
        err_count     = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        cycles        = 0;

        // reset dominates whatever sits on the inputs
        errs = err_count;
        repeat (4)
            drive_word($random(seed), $random(seed), 1'b0, 1'b0);
        @(negedge i_clk);
        check_bubble(32'h0);
        drive_word(32'h0, 32'h0, 1'b0, 1'b0);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        check_bubble(32'h0);
        repeat (2) @(posedge i_clk);
        report_test("reset state", errs);

        errs = err_count;
        for (int k = 0; k < 42; k++)
            drive_word(directed_words[k], 32'h1000 + 32'(k * 4), 1'b0, 1'b0);
        repeat (2) @(posedge i_clk);
        report_test("directed decode", errs);

        errs = err_count;
        for (int i = 0; i < RANDOM_WORDS; i++)
        begin
            word = $random(seed);
            if (i % 2 == 0)
                word[6:0] = {valid_ops[$unsigned($random(seed)) % 10], 2'b11};
            drive_word(word, $random(seed) & 32'hffff_fffc, 1'b0, 1'b0);
        end
        repeat (2) @(posedge i_clk);
        report_test("random decode", errs);

        // addi x1,x0,5 stays while sub waits behind stall
        errs = err_count;
        drive_word(32'h00500093, 32'h2000, 1'b0, 1'b0);
        repeat (4)
            drive_word(32'h402085b3, 32'h2004, 1'b1, 1'b0);
        @(negedge i_clk);
        compare_value("o_pc", 32'h2000, o_pc);
        compare_value("o_imm", 32'd5, o_imm);
        drive_word(32'h402085b3, 32'h2004, 1'b0, 1'b0);
        drive_word(32'h0, 32'h2008, 1'b0, 1'b0);
        repeat (2) @(posedge i_clk);
        report_test("stall", errs);

        errs = err_count;
        drive_word(32'h00208533, 32'h3000, 1'b0, 1'b0);
        drive_word(32'h0080aa03, 32'h3004, 1'b0, 1'b1);
        @(posedge i_clk);
        @(negedge i_clk);
        check_bubble(32'h3000);
        // flush wins over stall on a live load
        drive_word(32'h0080aa03, 32'h3008, 1'b0, 1'b0);
        drive_word(32'h0080aa03, 32'h300c, 1'b1, 1'b1);
        @(negedge i_clk);
        compare_value("o_pc", 32'h3008, o_pc);
        @(posedge i_clk);
        @(negedge i_clk);
        check_bubble(32'h3008);
        drive_word(32'h0080aa03, 32'h3010, 1'b0, 1'b0);
        repeat (2) @(posedge i_clk);
        report_test("flush", errs);

        $display("summary: %0d tests ok, %0d tests failing, %0d mismatches",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- logic/rv_decode.sv
`timescale 1ns/10ps

module rv_decode
(
    input  logic                              i_clk,
    input  logic                              i_arst_n,
    input  logic                              i_stall,
    input  logic                              i_flush,
    input  logic [rv_dec_pkg::XLEN-1:0]       i_instruction,
    input  logic [rv_dec_pkg::XLEN-1:0]       i_pc,
    output logic [rv_dec_pkg::XLEN-1:0]       o_pc,
    output logic [rv_dec_pkg::XLEN-1:0]       o_pc_next,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] o_rs2,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [rv_dec_pkg::XLEN-1:0]       o_imm,
    output logic [rv_dec_pkg::XLEN-1:0]       o_imm_jb,
    output rv_dec_pkg::alu_op_t               o_alu_op,
    output logic                              o_cmp_inv,
    output logic [2:0]                        o_funct3,
    output logic                              o_op1_pc,
    output rv_dec_pkg::op2_src_t              o_op2_src,
    output rv_dec_pkg::res_src_t              o_res_src,
    output logic                              o_reg_write,
    output logic                              o_inst_jal,
    output logic                              o_inst_jalr,
    output logic                              o_inst_branch,
    output logic                              o_inst_store,
    output logic                              o_inst_supported
);

    rv_dec_pkg::instr_class_t instr_class;

    rv_instr_if u_fields();

    // only sequential part of the stage
    rv_dec_stage_reg u_stage_reg
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next),
        .o_fields      (u_fields.src)
    );

    rv_dec_ctrl u_ctrl
    (
        .i_fields         (u_fields.dst),
        .o_class          (instr_class),
        .o_alu_op         (o_alu_op),
        .o_cmp_inv        (o_cmp_inv),
        .o_funct3         (o_funct3),
        .o_op1_pc         (o_op1_pc),
        .o_op2_src        (o_op2_src),
        .o_res_src        (o_res_src),
        .o_reg_write      (o_reg_write),
        .o_rs1            (o_rs1),
        .o_inst_jal       (o_inst_jal),
        .o_inst_jalr      (o_inst_jalr),
        .o_inst_branch    (o_inst_branch),
        .o_inst_store     (o_inst_store),
        .o_inst_supported (o_inst_supported)
    );

    rv_dec_imm u_imm
    (
        .i_fields (u_fields.dst),
        .i_class  (instr_class),
        .o_imm    (o_imm),
        .o_imm_jb (o_imm_jb)
    );

    assign o_rs2 = u_fields.rs2;
    assign o_rd  = u_fields.rd;

endmodule

//--- logic/rv_dec_imm.sv
`timescale 1ns/10ps

module rv_dec_imm
(
    rv_instr_if.dst                     i_fields,
    input  rv_dec_pkg::instr_class_t    i_class,
    output logic [rv_dec_pkg::XLEN-1:0] o_imm,
    output logic [rv_dec_pkg::XLEN-1:0] o_imm_jb
);

    logic [rv_dec_pkg::XLEN-1:0] imm_i;
    logic [rv_dec_pkg::XLEN-1:0] imm_s;
    logic [rv_dec_pkg::XLEN-1:0] imm_b;
    logic [rv_dec_pkg::XLEN-1:0] imm_u;
    logic [rv_dec_pkg::XLEN-1:0] imm_j;
    logic [rv_dec_pkg::XLEN-1:0] w;

    assign w = i_fields.instr;

    // sign bit is always instr[31]
    assign imm_i = {{21{w[31]}}, w[30:20]};
    assign imm_s = {{21{w[31]}}, w[30:25], w[11:7]};
    assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    assign imm_u = {w[31:12], 12'b0};
    assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

    always_comb
    begin
        if ((i_class == rv_dec_pkg::CLS_LUI) || (i_class == rv_dec_pkg::CLS_AUIPC))
            o_imm = imm_u;
        else if (i_class == rv_dec_pkg::CLS_STORE)
            o_imm = imm_s;
        else
            o_imm = imm_i;
    end

    // branch offset unless jal
    assign o_imm_jb = (i_class == rv_dec_pkg::CLS_JAL) ? imm_j : imm_b;

    // jump targets stay halfword aligned
    a_jb_aligned: assert property (@(i_fields.instr)
        o_imm_jb[0] !== 1'b1);

endmodule

//--- logic/rv_dec_ctrl.sv
`timescale 1ns/10ps

module rv_dec_ctrl
(
    rv_instr_if.dst                           i_fields,
    output rv_dec_pkg::instr_class_t          o_class,
    output rv_dec_pkg::alu_op_t               o_alu_op,
    output logic                              o_cmp_inv,
    output logic [2:0]                        o_funct3,
    output logic                              o_op1_pc,
    output rv_dec_pkg::op2_src_t              o_op2_src,
    output rv_dec_pkg::res_src_t              o_res_src,
    output logic                              o_reg_write,
    output logic [rv_dec_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic                              o_inst_jal,
    output logic                              o_inst_jalr,
    output logic                              o_inst_branch,
    output logic                              o_inst_store,
    output logic                              o_inst_supported
);

    logic                     is_full;
    logic                     is_none;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [11:0]              funct12;
    logic                     alt;
    logic                     legal;
    rv_dec_pkg::instr_class_t opc_class;
    rv_dec_pkg::instr_class_t cls;

    assign is_full = (i_fields.instr[1:0] == 2'b11);
    assign is_none = (i_fields.instr == '0);
    assign funct3  = i_fields.funct3;
    assign funct7  = i_fields.instr[31:25];
    assign funct12 = i_fields.instr[31:20];
    // funct7 of 32 selects sub and sra
    assign alt     = (funct7 == 7'b0100000);

    // class by opcode, plus whether funct fields are legal for it
    always_comb
    begin
        legal     = 1'b0;
        opc_class = rv_dec_pkg::CLS_UNSUPPORTED;
        case (i_fields.opcode)
            rv_dec_pkg::OPC_LOAD:
            begin
                opc_class = rv_dec_pkg::CLS_LOAD;
                legal     = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
            end
            rv_dec_pkg::OPC_STORE:
            begin
                opc_class = rv_dec_pkg::CLS_STORE;
                legal     = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            rv_dec_pkg::OPC_OP_IMM:
            begin
                opc_class = rv_dec_pkg::CLS_OP_IMM;
                if (funct3 == 3'b001)
                    legal = (funct7 == '0);
                else if (funct3 == 3'b101)
                    legal = (funct7 == '0) || alt;
                else
                    legal = 1'b1;
            end
            rv_dec_pkg::OPC_OP_REG:
            begin
                opc_class = rv_dec_pkg::CLS_OP_REG;
                legal     = (funct7 == '0) || (alt && (funct3 inside {3'b000, 3'b101}));
            end
            rv_dec_pkg::OPC_LUI:
            begin
                opc_class = rv_dec_pkg::CLS_LUI;
                legal     = 1'b1;
            end
            rv_dec_pkg::OPC_AUIPC:
            begin
                opc_class = rv_dec_pkg::CLS_AUIPC;
                legal     = 1'b1;
            end
            rv_dec_pkg::OPC_BRANCH:
            begin
                opc_class = rv_dec_pkg::CLS_BRANCH;
                legal     = (funct3[2:1] != 2'b01);
            end
            rv_dec_pkg::OPC_JAL:
            begin
                opc_class = rv_dec_pkg::CLS_JAL;
                legal     = 1'b1;
            end
            rv_dec_pkg::OPC_JALR:
            begin
                opc_class = rv_dec_pkg::CLS_JALR;
                legal     = (funct3 == 3'b000);
            end
            rv_dec_pkg::OPC_SYSTEM:
            begin
                // ecall and ebreak only
                opc_class = rv_dec_pkg::CLS_SYSTEM;
                legal     = (funct3 == 3'b000) && (funct12 inside {12'h000, 12'h001});
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
    end

    assign cls = is_none           ? rv_dec_pkg::CLS_NONE :
                 (is_full && legal) ? opc_class : rv_dec_pkg::CLS_UNSUPPORTED;

    always_comb
    begin
        o_alu_op = rv_dec_pkg::ALU_ADD;
        if ((cls == rv_dec_pkg::CLS_OP_IMM) || (cls == rv_dec_pkg::CLS_OP_REG))
        begin
            case (funct3)
                3'b000: o_alu_op = ((cls == rv_dec_pkg::CLS_OP_REG) && alt) ?
                                   rv_dec_pkg::ALU_SUB : rv_dec_pkg::ALU_ADD;
                3'b001: o_alu_op = rv_dec_pkg::ALU_SLL;
                3'b010: o_alu_op = rv_dec_pkg::ALU_CMP_LTS;
                3'b011: o_alu_op = rv_dec_pkg::ALU_CMP_LTU;
                3'b100: o_alu_op = rv_dec_pkg::ALU_XOR;
                3'b101: o_alu_op = alt ? rv_dec_pkg::ALU_SRA : rv_dec_pkg::ALU_SRL;
                3'b110: o_alu_op = rv_dec_pkg::ALU_OR;
                default: o_alu_op = rv_dec_pkg::ALU_AND;
            endcase
        end
        else if (cls == rv_dec_pkg::CLS_BRANCH)
        begin
            // bne, bge and bgeu reuse the compare with inversion
            case (funct3[2:1])
                2'b00: o_alu_op = rv_dec_pkg::ALU_CMP_EQ;
                2'b10: o_alu_op = rv_dec_pkg::ALU_CMP_LTS;
                default: o_alu_op = rv_dec_pkg::ALU_CMP_LTU;
            endcase
        end
    end

    assign o_class       = cls;
    assign o_inst_branch = (cls == rv_dec_pkg::CLS_BRANCH);
    assign o_inst_store  = (cls == rv_dec_pkg::CLS_STORE);
    assign o_inst_jal    = (cls == rv_dec_pkg::CLS_JAL);
    assign o_inst_jalr   = (cls == rv_dec_pkg::CLS_JALR);
    assign o_cmp_inv     = o_inst_branch & funct3[0];
    assign o_funct3      = is_full ? funct3 : rv_dec_pkg::FUNCT3_WORD;
    assign o_op1_pc      = (cls == rv_dec_pkg::CLS_AUIPC) || o_inst_jal;

    assign o_op2_src = o_inst_jal ? rv_dec_pkg::OP2_JUMP :
                       (cls inside {rv_dec_pkg::CLS_JALR, rv_dec_pkg::CLS_LOAD,
                                    rv_dec_pkg::CLS_OP_IMM, rv_dec_pkg::CLS_LUI,
                                    rv_dec_pkg::CLS_AUIPC, rv_dec_pkg::CLS_STORE}) ?
                       rv_dec_pkg::OP2_IMM : rv_dec_pkg::OP2_REG;

    assign o_res_src = (cls == rv_dec_pkg::CLS_LOAD) ? rv_dec_pkg::RES_MEMORY :
                       (o_inst_jal || o_inst_jalr) ? rv_dec_pkg::RES_PC_NEXT :
                       rv_dec_pkg::RES_ALU;

    assign o_reg_write = cls inside {rv_dec_pkg::CLS_LOAD, rv_dec_pkg::CLS_OP_IMM,
                                     rv_dec_pkg::CLS_OP_REG, rv_dec_pkg::CLS_LUI,
                                     rv_dec_pkg::CLS_AUIPC, rv_dec_pkg::CLS_JAL,
                                     rv_dec_pkg::CLS_JALR, rv_dec_pkg::CLS_SYSTEM};

    // lui adds its immediate to x0
    assign o_rs1 = (cls == rv_dec_pkg::CLS_LUI) ? '0 : i_fields.rs1;

    assign o_inst_supported = (cls != rv_dec_pkg::CLS_UNSUPPORTED);

    // checked on each new word from the stage register
    a_write_supported: assert property (@(i_fields.instr)
        o_reg_write |-> o_inst_supported);

endmodule

//--- logic/rv_dec_stage_reg.sv
`timescale 1ns/10ps

module rv_dec_stage_reg
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic [rv_dec_pkg::XLEN-1:0] i_instruction,
    input  logic [rv_dec_pkg::XLEN-1:0] i_pc,
    output logic [rv_dec_pkg::XLEN-1:0] o_pc,
    output logic [rv_dec_pkg::XLEN-1:0] o_pc_next,
    rv_instr_if.src                     o_fields
);

    logic [rv_dec_pkg::XLEN-1:0] instr_q;
    logic [rv_dec_pkg::XLEN-1:0] pc_q;

    // flush wins over stall, pc is kept on flush
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            instr_q <= '0;
            pc_q    <= '0;
        end
        else if (i_flush)
        begin
            instr_q <= '0;
        end
        else if (!i_stall)
        begin
            instr_q <= i_instruction;
            pc_q    <= i_pc;
        end
    end

    assign o_fields.instr  = instr_q;
    assign o_fields.opcode = rv_dec_pkg::opcode_t'(instr_q[6:2]);
    assign o_fields.rd     = instr_q[11:7];
    assign o_fields.rs1    = instr_q[19:15];
    assign o_fields.rs2    = instr_q[24:20];
    assign o_fields.funct3 = instr_q[14:12];

    assign o_pc      = pc_q;
    assign o_pc_next = pc_q + rv_dec_pkg::INSTR_STEP;

    // a flushed slot decodes as a bubble on the next cycle
    a_flush_bubble: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_flush |=> (instr_q == '0));

endmodule

//--- logic/rv_instr_if.sv
`timescale 1ns/10ps

interface rv_instr_if;

    // registered instruction and its sliced fields
    logic [rv_dec_pkg::XLEN-1:0]       instr;
    rv_dec_pkg::opcode_t               opcode;
    logic [rv_dec_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_dec_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_dec_pkg::REG_ADDR_W-1:0] rs2;
    logic [2:0]                        funct3;

    modport src
    (
        output instr, opcode, rd, rs1, rs2, funct3
    );

    modport dst
    (
        input instr, opcode, rd, rs1, rs2, funct3
    );

endinterface

//--- logic/rv_dec_pkg.sv
package rv_dec_pkg;

    // datapath and register file widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // sequential fetch step, no compressed words
    localparam logic [XLEN-1:0] INSTR_STEP = XLEN'(4);

    // funct3 reported for words that are not full 32-bit encodings
    localparam logic [2:0] FUNCT3_WORD = 3'd2;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP_REG = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011,
        OPC_SYSTEM = 5'b11100
    } opcode_t;

    typedef enum logic [3:0] {
        CLS_NONE, CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP_REG, CLS_LUI,
        CLS_AUIPC, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_SYSTEM, CLS_UNSUPPORTED
    } instr_class_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND,
        ALU_CMP_EQ, ALU_CMP_LTS, ALU_CMP_LTU
    } alu_op_t;

    // second ALU operand
    typedef enum logic [1:0] {
        OP2_REG, OP2_IMM, OP2_JUMP
    } op2_src_t;

    // register file write-back source
    typedef enum logic [1:0] {
        RES_ALU, RES_MEMORY, RES_PC_NEXT
    } res_src_t;

endpackage
